// ==== sram_tester_pkg.sv ====
package sram_tester_pkg;

    // chiplet bus widths
    typedef logic [8:0] addr_t;
    typedef logic [7:0] data_t;

    // high nibble of the first command byte
    typedef enum logic [3:0] {
        OP_SET_ADDR       = 4'd1,
        OP_WRITE_VAL      = 4'd2,
        OP_READ_ADDR      = 4'd3,
        OP_READ_VAL       = 4'd4,
        OP_SET_CLK        = 4'd5,
        OP_READ_CLK       = 4'd6,
        OP_SET_READ_DELAY = 4'd7
    } opcode_e;

    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_GET_ARG,
        CTRL_RUN_OP,
        CTRL_SEND_FIRST,
        CTRL_WAIT_FIRST,
        CTRL_SEND_SECOND,
        CTRL_WAIT_SECOND
    } ctrl_state_e;

    typedef enum logic [2:0] {
        CYC_IDLE,
        CYC_CLK_LOW,
        CYC_CLK_HIGH,
        CYC_READ_WAIT,
        CYC_DONE
    } cycle_state_e;

    // half-period of the slow sram clock, in system clocks
    localparam data_t DEFAULT_CLK_FACTOR = 8'd25;
    localparam data_t DEFAULT_READ_DELAY = 8'd4;

    // address bus parks at all ones between cycles
    localparam addr_t IDLE_ADDR = '1;

endpackage

// ==== sram_cmd_if.sv ====
`timescale 1ns/1ns

interface sram_cmd_if;

    // four-phase handshake
    logic req;
    logic ack;

    // request fields, held stable while req is high
    logic                   is_write;
    sram_tester_pkg::addr_t addr;
    sram_tester_pkg::data_t wdata;
    sram_tester_pkg::data_t clk_factor;
    sram_tester_pkg::data_t read_delay;

    // valid once ack rises on a read
    sram_tester_pkg::data_t rdata;

    modport ctrl (
        output req, is_write, addr, wdata, clk_factor, read_delay,
        input  ack, rdata
    );

    modport engine (
        input  req, is_write, addr, wdata, clk_factor, read_delay,
        output ack, rdata
    );

endinterface

// ==== uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx #(
    parameter int CLKS_PER_BIT = 100
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   i_rx,
    output sram_tester_pkg::data_t o_byte,
    output logic                   o_valid
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [CNT_W-1:0] HALF = CNT_W'((CLKS_PER_BIT - 1) / 2);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e              state;
    logic [CNT_W-1:0]       cnt;
    logic [2:0]             bit_idx;
    logic                   rx_meta;
    logic                   rx_sync;
    sram_tester_pkg::data_t shift_q;

    // two-flop synchronizer, idles high like the line
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= RX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            o_valid <= 1'b0;
            shift_q <= '0;
        end else begin
            o_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt <= '0;
                    if (!rx_sync) begin
                        state <= RX_START;
                    end
                end
                RX_START: begin
                    // recheck at mid start bit to reject glitches
                    if (cnt == HALF) begin
                        cnt     <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? RX_IDLE : RX_DATA;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == LAST) begin
                        cnt     <= '0;
                        // lsb first
                        shift_q <= {rx_sync, shift_q[7:1]};
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= RX_STOP;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (cnt == LAST) begin
                        // bad stop bit drops the byte
                        o_valid <= rx_sync;
                        state   <= RX_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    assign o_byte = shift_q;

endmodule

// ==== uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx #(
    parameter int CLKS_PER_BIT = 100
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   i_start,
    input  sram_tester_pkg::data_t i_byte,
    output logic                   o_tx,
    output logic                   o_busy,
    output logic                   o_done
);

    localparam int CNT_W = $clog2(CLKS_PER_BIT);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS_PER_BIT - 1);

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

    tx_state_e              state;
    logic [CNT_W-1:0]       cnt;
    logic [2:0]             bit_idx;
    sram_tester_pkg::data_t shift_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            o_done  <= 1'b0;
            shift_q <= '0;
        end else begin
            o_done <= 1'b0;
            if (state == TX_IDLE) begin
                cnt     <= '0;
                bit_idx <= '0;
                if (i_start) begin
                    shift_q <= i_byte;
                    state   <= TX_START;
                end
            end else if (cnt != LAST) begin
                cnt <= cnt + 1'b1;
            end else begin
                // end of one bit time
                cnt <= '0;
                case (state)
                    TX_START: state <= TX_DATA;
                    TX_DATA: begin
                        shift_q <= shift_q >> 1;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= TX_STOP;
                        end
                    end
                    default: begin
                        o_done <= 1'b1;
                        state  <= TX_IDLE;
                    end
                endcase
            end
        end
    end

    // line level from the bit being sent
    always_comb begin
        case (state)
            TX_START: o_tx = 1'b0;
            TX_DATA:  o_tx = shift_q[0];
            default:  o_tx = 1'b1;
        endcase
    end

    assign o_busy = (state != TX_IDLE);

endmodule

// ==== sram_cycle_engine.sv ====
`timescale 1ns/1ns

module sram_cycle_engine (
    input  logic                   clk,
    input  logic                   reset,
    input  sram_tester_pkg::data_t i_sram_q,
    output logic                   o_sram_clk,
    output logic                   o_sram_cen,
    output logic                   o_sram_wen,
    output sram_tester_pkg::addr_t o_sram_addr,
    output sram_tester_pkg::data_t o_sram_d,
    output logic                   o_sram_reading,
    output logic                   o_sram_writing,
    sram_cmd_if.engine             cmd
);

    sram_tester_pkg::cycle_state_e state;
    sram_tester_pkg::data_t        cnt;
    sram_tester_pkg::data_t        rdata_q;
    logic                          in_clock;
    logic                          last_cnt;
    logic                          sample;

    assign last_cnt = (cnt == '0);
    assign in_clock = (state == sram_tester_pkg::CYC_CLK_LOW) ||
                      (state == sram_tester_pkg::CYC_CLK_HIGH);

    // q is taken on the last cycle before ack
    assign sample = last_cnt && !cmd.is_write &&
                    ((state == sram_tester_pkg::CYC_READ_WAIT) ||
                     (state == sram_tester_pkg::CYC_CLK_HIGH && cmd.read_delay == '0));

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= sram_tester_pkg::CYC_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                sram_tester_pkg::CYC_IDLE: begin
                    if (cmd.req) begin
                        cnt   <= cmd.clk_factor - 8'd1;
                        state <= sram_tester_pkg::CYC_CLK_LOW;
                    end
                end
                sram_tester_pkg::CYC_CLK_LOW: begin
                    if (last_cnt) begin
                        cnt   <= cmd.clk_factor - 8'd1;
                        state <= sram_tester_pkg::CYC_CLK_HIGH;
                    end else begin
                        cnt <= cnt - 8'd1;
                    end
                end
                sram_tester_pkg::CYC_CLK_HIGH: begin
                    if (!last_cnt) begin
                        cnt <= cnt - 8'd1;
                    end else if (cmd.is_write || cmd.read_delay == '0) begin
                        state <= sram_tester_pkg::CYC_DONE;
                    end else begin
                        // hold clock high while the read data settles
                        cnt   <= cmd.read_delay - 8'd1;
                        state <= sram_tester_pkg::CYC_READ_WAIT;
                    end
                end
                sram_tester_pkg::CYC_READ_WAIT: begin
                    if (last_cnt) begin
                        state <= sram_tester_pkg::CYC_DONE;
                    end else begin
                        cnt <= cnt - 8'd1;
                    end
                end
                sram_tester_pkg::CYC_DONE: begin
                    if (!cmd.req) begin
                        state <= sram_tester_pkg::CYC_IDLE;
                    end
                end
                default: state <= sram_tester_pkg::CYC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sample) begin
            rdata_q <= i_sram_q;
        end
    end

    assign cmd.ack   = (state == sram_tester_pkg::CYC_DONE);
    assign cmd.rdata = rdata_q;

    assign o_sram_writing = in_clock && cmd.is_write;
    assign o_sram_reading = (in_clock || state == sram_tester_pkg::CYC_READ_WAIT) &&
                            !cmd.is_write;

    // pins park high with the address at all ones between cycles
    assign o_sram_clk  = (state != sram_tester_pkg::CYC_CLK_LOW);
    assign o_sram_cen  = !(o_sram_reading || o_sram_writing);
    assign o_sram_wen  = !o_sram_writing;
    assign o_sram_addr = o_sram_cen ? sram_tester_pkg::IDLE_ADDR : cmd.addr;
    assign o_sram_d    = o_sram_writing ? cmd.wdata : '0;

endmodule

// ==== cmd_controller.sv ====
`timescale 1ns/1ns

module cmd_controller (
    input  logic                   clk,
    input  logic                   reset,
    input  sram_tester_pkg::data_t i_rx_byte,
    input  logic                   i_rx_valid,
    input  logic                   i_tx_busy,
    input  logic                   i_tx_done,
    output logic                   o_tx_start,
    output sram_tester_pkg::data_t o_tx_byte,
    sram_cmd_if.ctrl               cmd
);

    sram_tester_pkg::ctrl_state_e state;
    sram_tester_pkg::opcode_e     op_q;
    logic                         addr_hi_q;
    sram_tester_pkg::addr_t       addr_q;
    sram_tester_pkg::data_t       wval_q;
    sram_tester_pkg::data_t       clk_factor_q;
    sram_tester_pkg::data_t       read_delay_q;
    logic                         req_q;
    logic                         is_write_q;
    sram_tester_pkg::data_t       first_byte;
    sram_tester_pkg::data_t       second_byte;

    // reply bytes for the read commands
    always_comb begin
        first_byte = {op_q, 4'b0000};
        case (op_q)
            sram_tester_pkg::OP_READ_ADDR: begin
                first_byte  = {op_q, 3'b000, addr_q[8]};
                second_byte = addr_q[7:0];
            end
            sram_tester_pkg::OP_READ_VAL: second_byte = cmd.rdata;
            default: second_byte = clk_factor_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= sram_tester_pkg::CTRL_IDLE;
            op_q         <= sram_tester_pkg::OP_SET_ADDR;
            addr_hi_q    <= 1'b0;
            addr_q       <= '0;
            wval_q       <= '0;
            clk_factor_q <= sram_tester_pkg::DEFAULT_CLK_FACTOR;
            read_delay_q <= sram_tester_pkg::DEFAULT_READ_DELAY;
            req_q        <= 1'b0;
            is_write_q   <= 1'b0;
            o_tx_start   <= 1'b0;
            o_tx_byte    <= '0;
        end else begin
            o_tx_start <= 1'b0;
            case (state)
                sram_tester_pkg::CTRL_IDLE: begin
                    if (i_rx_valid) begin
                        op_q      <= sram_tester_pkg::opcode_e'(i_rx_byte[7:4]);
                        addr_hi_q <= i_rx_byte[0];
                        case (sram_tester_pkg::opcode_e'(i_rx_byte[7:4]))
                            sram_tester_pkg::OP_SET_ADDR,
                            sram_tester_pkg::OP_WRITE_VAL,
                            sram_tester_pkg::OP_SET_CLK,
                            sram_tester_pkg::OP_SET_READ_DELAY:
                                state <= sram_tester_pkg::CTRL_GET_ARG;
                            sram_tester_pkg::OP_READ_ADDR,
                            sram_tester_pkg::OP_READ_CLK:
                                state <= sram_tester_pkg::CTRL_SEND_FIRST;
                            sram_tester_pkg::OP_READ_VAL: begin
                                req_q      <= 1'b1;
                                is_write_q <= 1'b0;
                                state      <= sram_tester_pkg::CTRL_RUN_OP;
                            end
                            // unknown opcodes fall through and are ignored
                            default: state <= sram_tester_pkg::CTRL_IDLE;
                        endcase
                    end
                end
                sram_tester_pkg::CTRL_GET_ARG: begin
                    if (i_rx_valid) begin
                        state <= sram_tester_pkg::CTRL_IDLE;
                        case (op_q)
                            sram_tester_pkg::OP_SET_ADDR:  addr_q <= {addr_hi_q, i_rx_byte};
                            sram_tester_pkg::OP_SET_CLK:   clk_factor_q <= i_rx_byte;
                            sram_tester_pkg::OP_WRITE_VAL: begin
                                wval_q     <= i_rx_byte;
                                req_q      <= 1'b1;
                                is_write_q <= 1'b1;
                                state      <= sram_tester_pkg::CTRL_RUN_OP;
                            end
                            default: read_delay_q <= i_rx_byte;
                        endcase
                    end
                end
                sram_tester_pkg::CTRL_RUN_OP: begin
                    // drop req on ack, finish once ack is back low
                    if (req_q && cmd.ack) begin
                        req_q <= 1'b0;
                    end else if (!req_q && !cmd.ack) begin
                        state <= is_write_q ? sram_tester_pkg::CTRL_IDLE
                                            : sram_tester_pkg::CTRL_SEND_FIRST;
                    end
                end
                sram_tester_pkg::CTRL_SEND_FIRST: begin
                    if (!i_tx_busy) begin
                        o_tx_start <= 1'b1;
                        o_tx_byte  <= first_byte;
                        state      <= sram_tester_pkg::CTRL_WAIT_FIRST;
                    end
                end
                sram_tester_pkg::CTRL_WAIT_FIRST: begin
                    if (i_tx_done) begin
                        state <= sram_tester_pkg::CTRL_SEND_SECOND;
                    end
                end
                sram_tester_pkg::CTRL_SEND_SECOND: begin
                    if (!i_tx_busy) begin
                        o_tx_start <= 1'b1;
                        o_tx_byte  <= second_byte;
                        state      <= sram_tester_pkg::CTRL_WAIT_SECOND;
                    end
                end
                sram_tester_pkg::CTRL_WAIT_SECOND: begin
                    if (i_tx_done) begin
                        state <= sram_tester_pkg::CTRL_IDLE;
                    end
                end
                default: state <= sram_tester_pkg::CTRL_IDLE;
            endcase
        end
    end

    assign cmd.req        = req_q;
    assign cmd.is_write   = is_write_q;
    assign cmd.addr       = addr_q;
    assign cmd.wdata      = wval_q;
    assign cmd.clk_factor = clk_factor_q;
    assign cmd.read_delay = read_delay_q;

endmodule

// ==== sram_tester_top.sv ====
`timescale 1ns/1ns

module sram_tester_top #(
    parameter int CLKS_PER_BIT = 100
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   i_rx,
    input  sram_tester_pkg::data_t i_sram_q,
    output logic                   o_tx,
    output logic                   o_sram_clk,
    output logic                   o_sram_cen,
    output logic                   o_sram_wen,
    output sram_tester_pkg::addr_t o_sram_addr,
    output sram_tester_pkg::data_t o_sram_d,
    output logic                   o_sram_reading,
    output logic                   o_sram_writing
);

    sram_tester_pkg::data_t rx_byte;
    logic                   rx_valid;
    sram_tester_pkg::data_t tx_byte;
    logic                   tx_start;
    logic                   tx_busy;
    logic                   tx_done;

    sram_cmd_if cmd_if ();

    uart_rx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_rx (
        .clk     (clk),
        .reset   (reset),
        .i_rx    (i_rx),
        .o_byte  (rx_byte),
        .o_valid (rx_valid)
    );

    uart_tx #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) u_tx (
        .clk     (clk),
        .reset   (reset),
        .i_start (tx_start),
        .i_byte  (tx_byte),
        .o_tx    (o_tx),
        .o_busy  (tx_busy),
        .o_done  (tx_done)
    );

    cmd_controller u_ctrl (
        .clk        (clk),
        .reset      (reset),
        .i_rx_byte  (rx_byte),
        .i_rx_valid (rx_valid),
        .i_tx_busy  (tx_busy),
        .i_tx_done  (tx_done),
        .o_tx_start (tx_start),
        .o_tx_byte  (tx_byte),
        .cmd        (cmd_if.ctrl)
    );

    sram_cycle_engine u_engine (
        .clk            (clk),
        .reset          (reset),
        .i_sram_q       (i_sram_q),
        .o_sram_clk     (o_sram_clk),
        .o_sram_cen     (o_sram_cen),
        .o_sram_wen     (o_sram_wen),
        .o_sram_addr    (o_sram_addr),
        .o_sram_d       (o_sram_d),
        .o_sram_reading (o_sram_reading),
        .o_sram_writing (o_sram_writing),
        .cmd            (cmd_if.engine)
    );

endmodule

// ==== tb_sram_tester_chk.sv ====
`timescale 1ns/1ns

module sram_tester_chk (
    input logic                   clk,
    input logic                   reset,
    input logic                   i_sram_clk,
    input logic                   i_sram_cen,
    input logic                   i_sram_wen,
    input sram_tester_pkg::addr_t i_sram_addr,
    input sram_tester_pkg::data_t i_sram_d,
    input logic                   i_sram_reading,
    input logic                   i_sram_writing,
    input logic                   i_req,
    input logic                   i_ack,
    input logic                   i_is_write,
    input sram_tester_pkg::addr_t i_addr,
    input sram_tester_pkg::data_t i_clk_factor,
    input sram_tester_pkg::data_t i_read_delay
);

    int unsigned fail_count = 0;

    logic [10:0] clk_low_cnt;
    logic [10:0] wr_cnt;
    logic [10:0] rd_cnt;
    logic [10:0] wr_len;
    logic [10:0] rd_len;

    // a write spans two half-periods, a read adds the read delay
    assign wr_len = {2'b00, i_clk_factor, 1'b0};
    assign rd_len = wr_len + {3'b000, i_read_delay};

    always_ff @(posedge clk) begin
        if (reset) begin
            clk_low_cnt <= '0;
            wr_cnt      <= '0;
            rd_cnt      <= '0;
        end else begin
            clk_low_cnt <= i_sram_clk ? 11'd0 : clk_low_cnt + 11'd1;
            wr_cnt      <= i_sram_writing ? wr_cnt + 11'd1 : 11'd0;
            rd_cnt      <= i_sram_reading ? rd_cnt + 11'd1 : 11'd0;
        end
    end

    // pins park outside a cycle
    idle_pins_a: assert property (@(posedge clk) disable iff (reset)
        !(i_sram_reading || i_sram_writing) |->
            i_sram_clk && i_sram_cen && i_sram_wen &&
            (i_sram_addr == sram_tester_pkg::IDLE_ADDR) && (i_sram_d == '0))
    else begin
        fail_count++;
        $error("sram pins not idle outside a cycle");
    end

    one_dir_a: assert property (@(posedge clk) disable iff (reset)
        !(i_sram_reading && i_sram_writing))
    else begin
        fail_count++;
        $error("reading and writing high together");
    end

    write_pins_a: assert property (@(posedge clk) disable iff (reset)
        i_sram_writing |-> !i_sram_cen && !i_sram_wen)
    else begin
        fail_count++;
        $error("cen or wen high during a write");
    end

    read_pins_a: assert property (@(posedge clk) disable iff (reset)
        i_sram_reading |-> !i_sram_cen && i_sram_wen)
    else begin
        fail_count++;
        $error("cen high or wen low during a read");
    end

    // slow clock low phase equals the clock factor
    clk_low_len_a: assert property (@(posedge clk) disable iff (reset)
        $rose(i_sram_clk) |-> clk_low_cnt == {3'b000, i_clk_factor})
    else begin
        fail_count++;
        $error("sram clock low phase has the wrong length");
    end

    write_len_a: assert property (@(posedge clk) disable iff (reset)
        $fell(i_sram_writing) |-> wr_cnt == wr_len)
    else begin
        fail_count++;
        $error("write cycle has the wrong length");
    end

    read_len_a: assert property (@(posedge clk) disable iff (reset)
        $fell(i_sram_reading) |-> rd_cnt == rd_len)
    else begin
        fail_count++;
        $error("read cycle has the wrong length");
    end

    // four-phase req/ack ordering
    req_rise_a: assert property (@(posedge clk) disable iff (reset)
        $rose(i_req) |-> !i_ack)
    else begin
        fail_count++;
        $error("req raised while ack still high");
    end

    ack_rise_a: assert property (@(posedge clk) disable iff (reset)
        $rose(i_ack) |-> i_req)
    else begin
        fail_count++;
        $error("ack raised without req");
    end

    req_fall_a: assert property (@(posedge clk) disable iff (reset)
        $fell(i_req) |-> $past(i_ack))
    else begin
        fail_count++;
        $error("req dropped before ack");
    end

    ack_fall_a: assert property (@(posedge clk) disable iff (reset)
        $fell(i_ack) |-> !$past(i_req))
    else begin
        fail_count++;
        $error("ack dropped while req still high");
    end

    req_fields_a: assert property (@(posedge clk) disable iff (reset)
        i_req && $past(i_req) |->
            $stable(i_addr) && $stable(i_is_write) && $stable(i_clk_factor))
    else begin
        fail_count++;
        $error("request fields changed while req high");
    end

endmodule

bind sram_tester_top sram_tester_chk chk0 (
    .clk            (clk),
    .reset          (reset),
    .i_sram_clk     (o_sram_clk),
    .i_sram_cen     (o_sram_cen),
    .i_sram_wen     (o_sram_wen),
    .i_sram_addr    (o_sram_addr),
    .i_sram_d       (o_sram_d),
    .i_sram_reading (o_sram_reading),
    .i_sram_writing (o_sram_writing),
    .i_req          (cmd_if.req),
    .i_ack          (cmd_if.ack),
    .i_is_write     (cmd_if.is_write),
    .i_addr         (cmd_if.addr),
    .i_clk_factor   (cmd_if.clk_factor),
    .i_read_delay   (cmd_if.read_delay)
);

// ==== tb_sram_tester.sv ====
`timescale 1ns/1ns

module tb_sram_tester;

    localparam int CLKS_PER_BIT   = 8;
    localparam int TIMEOUT_CYCLES = 4000;

    logic                   clk;
    logic                   reset;
    logic                   rx;
    sram_tester_pkg::data_t sram_q;
    logic                   tx;
    logic                   sram_clk;
    logic                   sram_cen;
    logic                   sram_wen;
    sram_tester_pkg::addr_t sram_addr;
    sram_tester_pkg::data_t sram_d;
    logic                   sram_reading;
    logic                   sram_writing;

    logic [7:0] mem [512];
    logic [7:0] q_next;
    logic [7:0] reply_q [$];
    int         err_count = 0;
    event       abort_ev;
    string      abort_why;

    sram_tester_top #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) dut0 (
        .clk            (clk),
        .reset          (reset),
        .i_rx           (rx),
        .i_sram_q       (sram_q),
        .o_tx           (tx),
        .o_sram_clk     (sram_clk),
        .o_sram_cen     (sram_cen),
        .o_sram_wen     (sram_wen),
        .o_sram_addr    (sram_addr),
        .o_sram_d       (sram_d),
        .o_sram_reading (sram_reading),
        .o_sram_writing (sram_writing)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // behavioral sram with a fill that depends on the whole address
    initial begin
        for (int a = 0; a < 512; a++) begin
            mem[a] = 8'(a * 29) ^ 8'(a >> 3);
        end
        q_next = '0;
    end

    always @(posedge sram_clk) begin
        if (!sram_cen && !sram_wen) begin
            mem[sram_addr] = sram_d;
        end
    end

    always @(negedge clk) begin
        q_next = mem[sram_addr];
    end

    always @(posedge clk) begin
        sram_q <= q_next;
    end

    task automatic abort_run(input string why);
        abort_why = why;
        -> abort_ev;
        // hold the caller here while the run ends
        forever @(posedge clk);
    endtask

    // end of the run after a timeout
    initial begin
        @(abort_ev);
        $display("%s", abort_why);
        $display("errors: %0d reply checks, %0d protocol assertions",
                 err_count, dut0.chk0.fail_count);
        $display("Test failures found");
        $finish;
    end

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp) else begin
            err_count++;
            $display("ERR %0t ns %s: got %02h, expected %02h", $time, name, got, exp);
        end
    endtask

    // start bit, eight data bits lsb first, stop bit
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            rx <= frame[i];
            repeat (CLKS_PER_BIT - 1) @(posedge clk);
        end
    endtask

    task automatic receive_frame();
        logic [7:0] b;
        b = '0;
        repeat (CLKS_PER_BIT / 2) @(negedge clk);
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            b[i] = tx;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        assert (tx === 1'b1) else begin
            err_count++;
            $display("framing error: o_tx stop bit low at %0t ns", $time);
        end
        reply_q.push_back(b);
    endtask

    // host side receiver
    initial begin
        forever begin
            @(negedge clk);
            if (tx === 1'b0) begin
                receive_frame();
            end
        end
    end

    task automatic wait_ctrl_idle();
        int n;
        n = 0;
        @(negedge clk);
        while (dut0.u_ctrl.state != sram_tester_pkg::CTRL_IDLE && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (n >= TIMEOUT_CYCLES) begin
            abort_run("timeout: command controller never returned to idle");
        end
    endtask

    task automatic get_reply(output logic [7:0] b);
        int n;
        n = 0;
        while (reply_q.size() == 0 && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (reply_q.size() == 0) begin
            abort_run("timeout: no reply byte on o_tx");
        end else begin
            b = reply_q.pop_front();
        end
    endtask

    task automatic send_command(input logic [7:0] first, input logic [7:0] arg);
        send_byte(first);
        send_byte(arg);
        wait_ctrl_idle();
    endtask

    task automatic read_command(input logic [7:0] first, output logic [7:0] r0,
                                output logic [7:0] r1);
        send_byte(first);
        get_reply(r0);
        get_reply(r1);
        wait_ctrl_idle();
    endtask

    task automatic expect_silence(input int cycles);
        int n;
        n = 0;
        while (reply_q.size() == 0 && n < cycles) begin
            @(negedge clk);
            n++;
        end
        assert (reply_q.size() == 0) else begin
            err_count++;
            $display("unexpected reply byte after an unknown opcode at %0t ns", $time);
            reply_q.delete();
        end
    endtask

    initial begin
        sram_tester_pkg::addr_t addr;
        logic [7:0]             data;
        logic [7:0]             r0;
        logic [7:0]             r1;

        void'($urandom(32'hb0ce));
        reset  <= 1'b1;
        rx     <= 1'b1;
        sram_q <= '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        repeat (4) @(posedge clk);

        // write then read back at default timing
        addr = 9'($urandom);
        data = mem[addr] ^ (8'($urandom) | 8'h01);
        send_command({sram_tester_pkg::OP_SET_ADDR, 3'b000, addr[8]}, addr[7:0]);
        send_command({sram_tester_pkg::OP_WRITE_VAL, 4'b0000}, data);
        check_byte("sram model byte", mem[addr], data);
        read_command({sram_tester_pkg::OP_READ_VAL, 4'b0000}, r0, r1);
        check_byte("o_tx read value byte 1", r0, {sram_tester_pkg::OP_READ_VAL, 4'b0000});
        check_byte("o_tx read value byte 2", r1, data);

        // address with bit 8 set
        addr = {1'b1, 8'($urandom)};
        send_command({sram_tester_pkg::OP_SET_ADDR, 3'b000, addr[8]}, addr[7:0]);
        read_command({sram_tester_pkg::OP_READ_ADDR, 4'b0000}, r0, r1);
        check_byte("o_tx read address byte 1", r0,
                   {sram_tester_pkg::OP_READ_ADDR, 3'b000, addr[8]});
        check_byte("o_tx read address byte 2", r1, addr[7:0]);

        // clock factor 3, then a short write
        send_command({sram_tester_pkg::OP_SET_CLK, 4'b0000}, 8'd3);
        read_command({sram_tester_pkg::OP_READ_CLK, 4'b0000}, r0, r1);
        check_byte("o_tx read clock byte 1", r0, {sram_tester_pkg::OP_READ_CLK, 4'b0000});
        check_byte("o_tx read clock byte 2", r1, 8'd3);
        addr = 9'($urandom);
        data = mem[addr] ^ (8'($urandom) | 8'h01);
        send_command({sram_tester_pkg::OP_SET_ADDR, 3'b000, addr[8]}, addr[7:0]);
        send_command({sram_tester_pkg::OP_WRITE_VAL, 4'b0000}, data);
        check_byte("sram model byte", mem[addr], data);

        // read delay 5 on top of clock factor 3
        send_command({sram_tester_pkg::OP_SET_READ_DELAY, 4'b0000}, 8'd5);
        read_command({sram_tester_pkg::OP_READ_VAL, 4'b0000}, r0, r1);
        check_byte("o_tx read value byte 1", r0, {sram_tester_pkg::OP_READ_VAL, 4'b0000});
        check_byte("o_tx read value byte 2", r1, data);

        // opcode 0xA has no meaning
        send_byte(8'hA0);
        expect_silence(40 * CLKS_PER_BIT);
        read_command({sram_tester_pkg::OP_READ_CLK, 4'b0000}, r0, r1);
        check_byte("o_tx read clock byte 1", r0, {sram_tester_pkg::OP_READ_CLK, 4'b0000});
        check_byte("o_tx read clock byte 2", r1, 8'd3);

        repeat (10) @(posedge clk);
        $display("errors: %0d reply checks, %0d protocol assertions",
                 err_count, dut0.chk0.fail_count);
        if (err_count == 0 && dut0.chk0.fail_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== project.f ====
sram_tester_pkg.sv
sram_cmd_if.sv
uart_rx.sv
uart_tx.sv
sram_cycle_engine.sv
cmd_controller.sv
sram_tester_top.sv
tb_sram_tester_chk.sv
tb_sram_tester.sv

// ==== Makefile ====
VERILATOR  := verilator
TOP        := tb_sram_tester
FILELIST   := project.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
RUN_FLAGS  := +verilator+error+limit+1000
PASS_MSG   := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
